//--- rtl/dcache_pkg.sv
// cache widths, processor and memory channel structs, way update bus, controller states
package dcache_pkg;

  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 64;
  localparam int STRB_W   = 8;
  localparam int OFFSET_W = 3;   // byte within the one-word line

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
  } cpu_req_t;

  // write ack and read data share this channel
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              we;
  } cpu_rsp_t;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;   // word aligned, full strobe implied
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                       line_we;
    logic [STRB_W-1:0]          strb;
    logic [DATA_W-1:0]          data;
    logic                       tag_we;
    logic [ADDR_W-OFFSET_W-1:0] tag;   // right aligned, sized for the widest tag
    logic                       set_valid;
    logic                       set_dirty;
    logic                       clr_dirty;
  } way_wr_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_RESPOND,
    ST_WB_ADDR,
    ST_WB_RSP,
    ST_REFILL_REQ,
    ST_REFILL_WAIT
  } ctrl_state_e;

endpackage

//--- rtl/dcache_way.sv
// one cache way: valid, dirty and tag arrays, byte-writable data array, hit compare
`timescale 1ns/1ps

module dcache_way #(
  parameter int  INDEX_WIDTH = 6,
  localparam int TAG_W       = dcache_pkg::ADDR_W - INDEX_WIDTH - dcache_pkg::OFFSET_W,
  localparam int DEPTH       = 1 << INDEX_WIDTH
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [INDEX_WIDTH-1:0]        index_i,
  input  logic [TAG_W-1:0]              tag_i,
  input  logic                          wr_en_i,
  input  dcache_pkg::way_wr_t           wr_i,
  output logic                          hit_o,
  output logic                          dirty_o,
  output logic [TAG_W-1:0]              tag_o,
  output logic [dcache_pkg::DATA_W-1:0] data_o
);

  logic [DEPTH-1:0]              valid_q;
  logic [DEPTH-1:0]              dirty_q;
  logic [TAG_W-1:0]              tag_mem  [DEPTH];
  logic [dcache_pkg::DATA_W-1:0] data_mem [DEPTH];
  logic [dcache_pkg::DATA_W-1:0] data_q;

  // tag side is combinational on the registered index
  assign tag_o   = tag_mem[index_i];
  assign hit_o   = valid_q[index_i] && (tag_o == tag_i);
  assign dirty_o = dirty_q[index_i];
  assign data_o  = data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (wr_en_i) begin
      if (wr_i.set_valid) valid_q[index_i] <= 1'b1;
      if (wr_i.set_dirty) begin
        dirty_q[index_i] <= 1'b1;
      end else if (wr_i.clr_dirty) begin
        dirty_q[index_i] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en_i && wr_i.tag_we) tag_mem[index_i] <= wr_i.tag[TAG_W-1:0];
  end

  always_ff @(posedge clk) begin
    data_q <= data_mem[index_i];   // sync read, old word on a write edge
  end

  // strobe-masked merge
  always_ff @(posedge clk) begin
    if (wr_en_i && wr_i.line_we) begin
      for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
        if (wr_i.strb[b]) data_mem[index_i][8*b +: 8] <= wr_i.data[8*b +: 8];
      end
    end
  end

endmodule

//--- rtl/dcache_ctrl.sv
// cache controller FSM: hit select, round-robin victim, write-back, refill, response
`timescale 1ns/1ps

module dcache_ctrl #(
  parameter int  INDEX_WIDTH = 6,
  localparam int TAG_W       = dcache_pkg::ADDR_W - INDEX_WIDTH - dcache_pkg::OFFSET_W
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               req_valid_i,
  output logic                               req_ready_o,
  input  dcache_pkg::cpu_req_t               req_i,
  output logic                               rsp_valid_o,
  input  logic                               rsp_ready_i,
  output dcache_pkg::cpu_rsp_t               rsp_o,
  output logic                               mem_req_valid_o,
  input  logic                               mem_req_ready_i,
  output dcache_pkg::mem_req_t               mem_req_o,
  input  logic                               mem_rsp_valid_i,
  output logic                               mem_rsp_ready_o,
  input  logic [dcache_pkg::DATA_W-1:0]      mem_rsp_data_i,
  input  logic [1:0]                         hit_i,
  input  logic [1:0]                         dirty_i,
  input  logic [1:0][TAG_W-1:0]              tag_i,
  input  logic [1:0][dcache_pkg::DATA_W-1:0] data_i,
  output logic [INDEX_WIDTH-1:0]             index_o,
  output logic [TAG_W-1:0]                   tag_o,
  output dcache_pkg::way_wr_t                way_wr_o,
  output logic [1:0]                         way_sel_o
);

  dcache_pkg::ctrl_state_e state_q;
  dcache_pkg::cpu_req_t    req_q;
  logic                    way_q;      // hit way, or victim on a miss
  logic                    rr_q;
  logic                    hit;
  logic                    hit_way;
  logic                    first_rsp;
  logic                    mem_load;
  logic                    is_wb;

  assign index_o = req_q.addr[dcache_pkg::OFFSET_W +: INDEX_WIDTH];
  assign tag_o   = req_q.addr[dcache_pkg::ADDR_W-1 -: TAG_W];

  assign hit     = |hit_i;
  assign hit_way = hit_i[1];   // at most one way hits

  assign req_ready_o     = (state_q == dcache_pkg::ST_IDLE);
  assign mem_rsp_ready_o = (state_q == dcache_pkg::ST_WB_RSP) ||
                           (state_q == dcache_pkg::ST_REFILL_WAIT);

  // first respond cycle, before valid rises
  assign first_rsp = (state_q == dcache_pkg::ST_RESPOND) && !rsp_valid_o;
  assign is_wb     = (state_q == dcache_pkg::ST_WB_ADDR);
  assign mem_load  = !mem_req_valid_o && (is_wb || state_q == dcache_pkg::ST_REFILL_REQ);

  // free running victim pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      rr_q <= 1'b0;
    end else begin
      rr_q <= ~rr_q;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) req_q <= req_i;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q         <= dcache_pkg::ST_IDLE;
      rsp_valid_o     <= 1'b0;
      mem_req_valid_o <= 1'b0;
      way_q           <= 1'b0;
    end else begin
      case (state_q)
        dcache_pkg::ST_IDLE: begin
          if (req_valid_i) state_q <= dcache_pkg::ST_LOOKUP;
        end
        dcache_pkg::ST_LOOKUP: begin
          if (hit) begin
            way_q   <= hit_way;
            state_q <= dcache_pkg::ST_RESPOND;
          end else begin
            way_q   <= rr_q;
            state_q <= dirty_i[rr_q] ? dcache_pkg::ST_WB_ADDR : dcache_pkg::ST_REFILL_REQ;
          end
        end
        dcache_pkg::ST_RESPOND: begin
          if (!rsp_valid_o) begin
            rsp_valid_o <= 1'b1;
          end else if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
            state_q     <= dcache_pkg::ST_IDLE;
          end
        end
        dcache_pkg::ST_WB_ADDR: begin
          if (!mem_req_valid_o) begin
            mem_req_valid_o <= 1'b1;
          end else if (mem_req_ready_i) begin
            mem_req_valid_o <= 1'b0;
            state_q         <= dcache_pkg::ST_WB_RSP;
          end
        end
        dcache_pkg::ST_WB_RSP: begin
          if (mem_rsp_valid_i) state_q <= dcache_pkg::ST_REFILL_REQ;   // ack only
        end
        dcache_pkg::ST_REFILL_REQ: begin
          if (!mem_req_valid_o) begin
            mem_req_valid_o <= 1'b1;
          end else if (mem_req_ready_i) begin
            mem_req_valid_o <= 1'b0;
            state_q         <= dcache_pkg::ST_REFILL_WAIT;
          end
        end
        dcache_pkg::ST_REFILL_WAIT: begin
          // back through lookup, the filled way now hits
          if (mem_rsp_valid_i) state_q <= dcache_pkg::ST_LOOKUP;
        end
        default: state_q <= dcache_pkg::ST_IDLE;
      endcase
    end
  end

  // held stable until the handshake
  always_ff @(posedge clk) begin
    if (first_rsp) begin
      rsp_o.rdata <= data_i[way_q];
      rsp_o.we    <= req_q.we;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_load) begin
      mem_req_o.we    <= is_wb;
      mem_req_o.wdata <= data_i[way_q];   // victim word, ignored on refill
      if (is_wb) begin
        mem_req_o.addr <= {tag_i[way_q], index_o, {dcache_pkg::OFFSET_W{1'b0}}};
      end else begin
        mem_req_o.addr <= {tag_o, index_o, {dcache_pkg::OFFSET_W{1'b0}}};
      end
    end
  end

  always_comb begin
    way_wr_o  = '0;
    way_sel_o = '0;
    if (first_rsp && req_q.we) begin
      way_sel_o[way_q]   = 1'b1;
      way_wr_o.line_we   = 1'b1;
      way_wr_o.strb      = req_q.strb;
      way_wr_o.data      = req_q.wdata;
      way_wr_o.set_dirty = 1'b1;
    end else if (state_q == dcache_pkg::ST_REFILL_WAIT && mem_rsp_valid_i) begin
      way_sel_o[way_q]         = 1'b1;
      way_wr_o.line_we         = 1'b1;
      way_wr_o.strb            = '1;
      way_wr_o.data            = mem_rsp_data_i;
      way_wr_o.tag_we          = 1'b1;
      way_wr_o.tag[TAG_W-1:0]  = tag_o;
      way_wr_o.set_valid       = 1'b1;
      way_wr_o.clr_dirty       = 1'b1;
    end
  end

endmodule

//--- rtl/dcache_top.sv
// data cache top: two way banks side by side and the controller
`timescale 1ns/1ps

module dcache_top #(
  parameter int  INDEX_WIDTH = 6,
  localparam int TAG_W       = dcache_pkg::ADDR_W - INDEX_WIDTH - dcache_pkg::OFFSET_W
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  dcache_pkg::cpu_req_t          req_i,
  output logic                          rsp_valid_o,
  input  logic                          rsp_ready_i,
  output dcache_pkg::cpu_rsp_t          rsp_o,
  output logic                          mem_req_valid_o,
  input  logic                          mem_req_ready_i,
  output dcache_pkg::mem_req_t          mem_req_o,
  input  logic                          mem_rsp_valid_i,
  output logic                          mem_rsp_ready_o,
  input  logic [dcache_pkg::DATA_W-1:0] mem_rsp_data_i
);

  logic [INDEX_WIDTH-1:0]             index;
  logic [TAG_W-1:0]                   lookup_tag;
  dcache_pkg::way_wr_t                way_wr;
  logic [1:0]                         way_sel;
  logic [1:0]                         way_hit;
  logic [1:0]                         way_dirty;
  logic [1:0][TAG_W-1:0]              way_tag;
  logic [1:0][dcache_pkg::DATA_W-1:0] way_data;

  for (genvar w = 0; w < 2; w++) begin : g_way
    dcache_way #(
      .INDEX_WIDTH (INDEX_WIDTH)
    ) u_way (
      .clk     (clk),
      .rst     (rst),
      .index_i (index),
      .tag_i   (lookup_tag),
      .wr_en_i (way_sel[w]),
      .wr_i    (way_wr),
      .hit_o   (way_hit[w]),
      .dirty_o (way_dirty[w]),
      .tag_o   (way_tag[w]),
      .data_o  (way_data[w])
    );
  end

  dcache_ctrl #(
    .INDEX_WIDTH (INDEX_WIDTH)
  ) u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_i           (req_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_o           (rsp_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_o       (mem_req_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_ready_o (mem_rsp_ready_o),
    .mem_rsp_data_i  (mem_rsp_data_i),
    .hit_i           (way_hit),
    .dirty_i         (way_dirty),
    .tag_i           (way_tag),
    .data_i          (way_data),
    .index_o         (index),
    .tag_o           (lookup_tag),
    .way_wr_o        (way_wr),
    .way_sel_o       (way_sel)
  );

endmodule

//--- bench/mem_model.sv
// memory slave model: random ready and response delays, word store with address based fill
`timescale 1ns/1ps

module mem_model #(
  parameter logic [63:0] INIT_XOR = 64'h0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  dcache_pkg::mem_req_t          req_i,
  output logic                          rsp_valid_o,
  input  logic                          rsp_ready_i,
  output logic [dcache_pkg::DATA_W-1:0] rsp_data_o
);

  logic [dcache_pkg::DATA_W-1:0] mem_q [logic [dcache_pkg::ADDR_W-1:0]];
  dcache_pkg::mem_req_t          req;
  logic                          took;

  // untouched words read as their address xor a constant
  function automatic logic [63:0] fill_word(input logic [31:0] addr);
    return {32'h0, addr} ^ INIT_XOR;
  endfunction

  initial begin
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    forever begin
      @(negedge clk);
      if (!rst && req_valid_i) begin
        repeat ($urandom % 4) @(negedge clk);
        req_ready_o = 1'b1;
        req         = req_i;
        @(negedge clk);   // taken on the edge in between
        req_ready_o = 1'b0;
        if (req.we) begin
          mem_q[req.addr] = req.wdata;
          rsp_data_o      = '0;   // write ack only
        end else begin
          rsp_data_o = mem_q.exists(req.addr) ? mem_q[req.addr] : fill_word(req.addr);
        end
        repeat ($urandom % 4) @(negedge clk);
        rsp_valid_o = 1'b1;
        took        = 1'b0;
        while (!took) begin
          took = rsp_ready_i;
          @(negedge clk);
        end
        rsp_valid_o = 1'b0;
      end
    end
  end

endmodule

//--- bench/tb_dcache.sv
// data cache testbench with clock, reset, random traffic, shadow memory, checks and watchdog
`timescale 1ns/1ps

module tb_dcache;

  localparam int          INDEX_WIDTH = 6;
  localparam int          TAG_W       = dcache_pkg::ADDR_W - INDEX_WIDTH - dcache_pkg::OFFSET_W;
  localparam int          NUM_ITER    = 250;
  localparam int          MAX_REQ     = 2 * NUM_ITER;   // up to two requests per iteration
  localparam logic [63:0] INIT_XOR    = 64'h5a5a_c3c3_0f0f_9669;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   req_valid;
  logic                   req_ready;
  dcache_pkg::cpu_req_t   req;
  logic                   rsp_valid;
  logic                   rsp_ready;
  dcache_pkg::cpu_rsp_t   rsp;
  logic                   mem_req_valid;
  logic                   mem_req_ready;
  dcache_pkg::mem_req_t   mem_req;
  logic                   mem_rsp_valid;
  logic                   mem_rsp_ready;
  logic [63:0]            mem_rsp_data;

  logic [63:0]            shadow  [logic [31:0]];
  bit                     written [logic [31:0]];
  logic [TAG_W-1:0]       tag_pool   [4] = '{23'h00_0001, 23'h12_3456, 23'h2a_5a5a, 23'h7f_ff00};
  logic [INDEX_WIDTH-1:0] index_pool [4] = '{6'd0, 6'd17, 6'd40, 6'd63};
  int                     checks = 0;
  int                     errors = 0;
  int                     edge_cnt = 0;
  bit                     rsp_stalled;
  bit                     mem_stalled;
  dcache_pkg::cpu_rsp_t   rsp_prev;
  dcache_pkg::mem_req_t   mem_prev;

  always #5 clk = ~clk;

  dcache_top #(
    .INDEX_WIDTH (INDEX_WIDTH)
  ) DUT (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .req_i           (req),
    .rsp_valid_o     (rsp_valid),
    .rsp_ready_i     (rsp_ready),
    .rsp_o           (rsp),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_req_o       (mem_req),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_ready_o (mem_rsp_ready),
    .mem_rsp_data_i  (mem_rsp_data)
  );

  mem_model #(
    .INIT_XOR (INIT_XOR)
  ) u_mem (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (mem_req_valid),
    .req_ready_o (mem_req_ready),
    .req_i       (mem_req),
    .rsp_valid_o (mem_rsp_valid),
    .rsp_ready_i (mem_rsp_ready),
    .rsp_data_o  (mem_rsp_data)
  );

  function automatic logic [31:0] word_addr(input logic [31:0] addr);
    return {addr[31:3], 3'b000};
  endfunction

  function automatic logic [63:0] shadow_word(input logic [31:0] addr);
    if (shadow.exists(word_addr(addr))) return shadow[word_addr(addr)];
    return {32'h0, word_addr(addr)} ^ INIT_XOR;   // memory fill pattern
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_w, input logic [63:0] new_w,
                                              input logic [7:0] strb);
    logic [63:0] res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // few tags on few sets so the two ways overflow
  function automatic logic [31:0] pick_addr();
    return {tag_pool[2'($urandom)], index_pool[2'($urandom)], 3'($urandom)};
  endfunction

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    errors++;
    $display("error: %s got %h expected %h", name, got, exp);
  endtask

  task automatic run_request(input logic we, input logic [31:0] addr, input logic [63:0] wdata,
                             input logic [7:0] strb, input bit expect_hit);
    logic [63:0] exp_data;
    int          accept_edge;
    bit          seen_valid;
    bit          done;
    req_valid = 1'b1;
    req.we    = we;
    req.addr  = addr;
    req.wdata = wdata;
    req.strb  = strb;
    while (!req_ready) @(negedge clk);
    @(negedge clk);   // accepted on the edge just passed
    req_valid   = 1'b0;
    accept_edge = edge_cnt;
    exp_data    = shadow_word(addr);
    if (we) begin
      shadow[word_addr(addr)]  = merge_bytes(exp_data, wdata, strb);
      written[word_addr(addr)] = 1'b1;
    end
    seen_valid = 1'b0;
    done       = 1'b0;
    while (!done) begin
      rsp_ready = ($urandom % 3) != 0;   // stall about a third of the time
      if (expect_hit) begin
        checks++;
        assert (!mem_req_valid) else begin
          errors++;
          $display("memory request seen during a read that should hit, address %h", addr);
        end
      end
      if (rsp_valid && !seen_valid && expect_hit) begin
        checks++;
        assert (edge_cnt - accept_edge == 2) else
          report_mismatch("rsp_valid_o delay", 128'(edge_cnt - accept_edge), 128'd2);
      end
      seen_valid = seen_valid || rsp_valid;
      if (rsp_valid && rsp_ready) begin
        checks++;
        assert (rsp.we == we) else report_mismatch("rsp_o.we", 128'(rsp.we), 128'(we));
        if (!we) begin
          checks++;
          assert (rsp.rdata == exp_data) else
            report_mismatch("rsp_o.rdata", 128'(rsp.rdata), 128'(exp_data));
        end
        done = 1'b1;
      end
      @(negedge clk);
    end
    rsp_ready = 1'b0;
  endtask

  // stability under back-pressure and write-back data
  always @(posedge clk) begin
    edge_cnt++;
    if (!rst) begin
      if (rsp_stalled) begin
        checks++;
        assert (rsp_valid) else begin
          errors++;
          $display("rsp_valid_o dropped before the response was taken");
        end
        checks++;
        assert (rsp == rsp_prev) else report_mismatch("rsp_o", 128'(rsp), 128'(rsp_prev));
      end
      if (mem_stalled) begin
        checks++;
        assert (mem_req_valid) else begin
          errors++;
          $display("mem_req_valid_o dropped before the request was taken");
        end
        checks++;
        assert (mem_req == mem_prev) else
          report_mismatch("mem_req_o", 128'(mem_req), 128'(mem_prev));
      end
      if (mem_req_valid && mem_req_ready && mem_req.we) begin
        checks++;
        assert (written.exists(mem_req.addr)) else begin
          errors++;
          $display("write-back of word %h that was never written", mem_req.addr);
        end
        checks++;
        assert (mem_req.wdata == shadow_word(mem_req.addr)) else
          report_mismatch("mem_req_o.wdata", 128'(mem_req.wdata), 128'(shadow_word(mem_req.addr)));
      end
    end
    rsp_stalled = !rst && rsp_valid && !rsp_ready;
    rsp_prev    = rsp;
    mem_stalled = !rst && mem_req_valid && !mem_req_ready;
    mem_prev    = mem_req;
  end

  initial begin
    logic [31:0] addr;
    int          kind;
    void'($urandom(32'h9cc6_2409));
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    repeat (3) begin
      @(negedge clk);
      checks++;
      assert (req_ready && !rsp_valid && !mem_req_valid && !mem_rsp_ready) else begin
        errors++;
        $display(
          "error: after reset req_ready_o %h rsp_valid_o %h mem_req_valid_o %h mem_rsp_ready_o %h",
          req_ready, rsp_valid, mem_req_valid, mem_rsp_ready);
      end
    end
    for (int i = 0; i < NUM_ITER; i++) begin
      addr = pick_addr();
      kind = $urandom % 3;
      if (kind == 0) begin
        run_request(1'b0, addr, '0, '0, 1'b0);
        if ($urandom % 2 == 0) run_request(1'b0, addr, '0, '0, 1'b1);   // same word so it must hit
      end else begin
        run_request(1'b1, addr, {$urandom, $urandom}, 8'($urandom), 1'b0);
        if (kind == 1) run_request(1'b0, addr, '0, '0, 1'b1);
      end
      repeat ($urandom % 2) @(negedge clk);
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    repeat (MAX_REQ * 200) @(posedge clk);
    $display("timeout after %0d cycles, checks %0d errors %0d", MAX_REQ * 200, checks, errors);
    $display("Test failed");
    $finish;
  end

endmodule

//--- list.f
rtl/dcache_pkg.sv
rtl/dcache_way.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
bench/mem_model.sv
bench/tb_dcache.sv

//--- run.sh
#!/bin/sh
# build the data cache testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_dcache -o sim_dcache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
